// ==== source/nnLayerPkg.sv ====
`default_nettype none

package nnLayerPkg;

	// ~~~~~~~~~~~~~~~~~~~~
	// sizes
	// ~~~~~~~~~~~~~~~~~~~~
	localparam int DATA_W  = 16;
	localparam int INPUTS  = 15;
	localparam int NEURONS = 8;
	localparam int WIN_W   = $clog2(NEURONS); // argmax index width

	typedef logic signed [DATA_W-1:0] weight_t;

	// one activation vector, word i feeds weight column i
	typedef logic [INPUTS-1:0][DATA_W-1:0] activation_t;

	typedef struct packed {
		logic [NEURONS-1:0][DATA_W-1:0] values;   // relu outputs, all neurons
		logic [WIN_W-1:0]               winner;   // index of largest value
		logic [DATA_W-1:0]              winValue; // largest value
	} layerResult_t;

	// ~~~~~~~~~~~~~~~~~~~~
	// weight and bias tables
	// ~~~~~~~~~~~~~~~~~~~~
	// row n belongs to neuron n, column i to input i
	localparam weight_t WEIGHTS [NEURONS][INPUTS] = '{
		'{  8, -14,  -9, -25,  12, -25, -12, -12,   1,  -4,   2,   9,  -6,  -5,  -4 },
		'{  3,  -2,   5,   1,  -7,   4,   0,   6,  -1,   2,  -3,   8,  -4,   1,   5 },
		'{ -6,   9,   2,  -3,   4,  -8,   7,   1,   3,  -5,   6,  -2,   0,   4,  -1 },
		'{  1,   1,  -1,   2,  -2,   3,  -3,   4,  -4,   5,  -5,   6,  -6,   7,  -7 },
		'{ 10,  -3,   0,   7,  -9,   2,   5,  -6,   8,  -1,   3,  -4,  11,  -2,   6 },
		'{ -2,   6,  -5,   3,   9,  -7,   1,  -4,   2,   8,  -6,   5,  -3,   0,   7 },
		'{  7,   0,   4,  -8,   1,   6,  -2,   3,  -9,   4,   2,  -7,   5,  -1,   3 },
		'{ -4,   5,   8,  -1,  -6,   3,   9,  -2,   0,  -3,   7,   1,  -8,   6,  -5 }
	};

	// neurons 3 and 5 share the top bias
	localparam weight_t BIASES [NEURONS] = '{
		0,
		4,
		-3,
		10,
		2,
		10,
		-6,
		1
	};

endpackage

`default_nettype wire

// ==== source/activationInput.sv ====
`timescale 1ns/100ps
`default_nettype none

module activationInput (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    inValid,
	input  nnLayerPkg::activation_t inData,
	output logic                    actValid,
	output nnLayerPkg::activation_t actData
);

	// ~~~~~~~~~~~~~~~~~~~~
	// input register
	// ~~~~~~~~~~~~~~~~~~~~
	// one registered copy drives every neuron, keeps fanout off the inputs

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actValid <= 1'b0;
			actData  <= '0;
		end
		else
		begin
			actValid <= inValid; // strobe rides with its vector
			actData  <= inData;
		end
	end

endmodule

`default_nettype wire

// ==== source/reluNeuron.sv ====
`timescale 1ns/100ps
`default_nettype none

module reluNeuron #(
	parameter int INDEX  = 0,
	parameter int INPUTS = nnLayerPkg::INPUTS
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          actValid,
	input  nnLayerPkg::activation_t       actData,
	output logic                          neuronValid,
	output logic [nnLayerPkg::DATA_W-1:0] neuronOut
);

	import nnLayerPkg::*;

	logic [INPUTS-1:0][DATA_W-1:0] product;
	logic                          productValid;
	logic [DATA_W-1:0]             sum;

	// ~~~~~~~~~~~~~~~~~~~~
	// stage one, products
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
			productValid <= 1'b0;
		else
			productValid <= actValid;
	end

	// low 16 bits only, product wraps
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < INPUTS; i++)
			product[i] <= DATA_W'($signed(actData[i]) * WEIGHTS[INDEX][i]);
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// stage two, sum and relu
	// ~~~~~~~~~~~~~~~~~~~~

	// accumulate in DATA_W bits so the sum wraps like the products
	always_comb
	begin
		sum = BIASES[INDEX];
		for (int i = 0; i < INPUTS; i++)
			sum = sum + product[i];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			neuronValid <= 1'b0;
		else
			neuronValid <= productValid;
	end

	always_ff @(posedge clk)
	begin
		if (sum[DATA_W-1])
			neuronOut <= '0; // negative clamps to zero
		else
			neuronOut <= sum;
	end

endmodule

`default_nettype wire

// ==== source/argmaxOutput.sv ====
`timescale 1ns/100ps
`default_nettype none

module argmaxOutput #(
	parameter int NEURONS = nnLayerPkg::NEURONS
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic [NEURONS-1:0]                          neuronValid,
	input  logic [NEURONS-1:0][nnLayerPkg::DATA_W-1:0]  neuronOut,
	output logic                                        outValid,
	output nnLayerPkg::layerResult_t                    result
);

	import nnLayerPkg::*;

	logic              strobe;
	logic [WIN_W-1:0]  bestIndex;
	logic [DATA_W-1:0] bestValue;

	// neurons run in lockstep, any one valid stands for all
	assign strobe = neuronValid[0];

	// ~~~~~~~~~~~~~~~~~~~~
	// argmax search
	// ~~~~~~~~~~~~~~~~~~~~
	// linear scan, strict compare keeps the lower index on a tie

	always_comb
	begin
		bestIndex = '0;
		bestValue = neuronOut[0];
		for (int i = 1; i < NEURONS; i++)
		begin
			if (neuronOut[i] > bestValue) // unsigned compare
			begin
				bestIndex = WIN_W'(i);
				bestValue = neuronOut[i];
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// result register
	// ~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk)
	begin
		if (reset)
			outValid <= 1'b0;
		else
			outValid <= strobe;
	end

	// result holds between vectors
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else if (strobe)
		begin
			result.values   <= neuronOut;
			result.winner   <= bestIndex;
			result.winValue <= bestValue;
		end
	end

endmodule

`default_nettype wire

// ==== source/denseLayer.sv ====
`timescale 1ns/100ps
`default_nettype none

module denseLayer #(
	parameter int INPUTS  = nnLayerPkg::INPUTS,
	parameter int NEURONS = nnLayerPkg::NEURONS
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     inValid,
	input  nnLayerPkg::activation_t  inData,
	output logic                     outValid,
	output nnLayerPkg::layerResult_t result
);

	import nnLayerPkg::*;

	logic                           actValid;
	activation_t                    actData;
	logic [NEURONS-1:0]             neuronValid;
	logic [NEURONS-1:0][DATA_W-1:0] neuronOut;

	// ~~~~~~~~~~~~~~~~~~~~
	// input stage, cycle 1
	// ~~~~~~~~~~~~~~~~~~~~

	activationInput uInput (
		.clk      (clk),
		.reset    (reset),
		.inValid  (inValid),
		.inData   (inData),
		.actValid (actValid),
		.actData  (actData)
	);

	// ~~~~~~~~~~~~~~~~~~~~
	// neurons, cycles 2 and 3
	// ~~~~~~~~~~~~~~~~~~~~

	// each instance picks its own table row by index
	genvar n;
	generate
		for (n = 0; n < NEURONS; n++)
		begin : gNeuron
			reluNeuron #(
				.INDEX  (n),
				.INPUTS (INPUTS)
			) uNeuron (
				.clk         (clk),
				.reset       (reset),
				.actValid    (actValid),
				.actData     (actData),
				.neuronValid (neuronValid[n]),
				.neuronOut   (neuronOut[n])
			);
		end
	endgenerate

	// ~~~~~~~~~~~~~~~~~~~~
	// output stage, cycle 4
	// ~~~~~~~~~~~~~~~~~~~~

	argmaxOutput #(
		.NEURONS (NEURONS)
	) uArgmax (
		.clk         (clk),
		.reset       (reset),
		.neuronValid (neuronValid),
		.neuronOut   (neuronOut),
		.outValid    (outValid),
		.result      (result)
	);

endmodule

`default_nettype wire

// ==== bench/denseLayer_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module denseLayer_chk (
	input logic                     clk,
	input logic                     reset,
	input logic                     inValid,
	input logic                     outValid,
	input nnLayerPkg::layerResult_t result
);

	int failCount = 0; // read by the testbench

	// ~~~~~~~~~~~~~~~~~~~~
	// valid timing
	// ~~~~~~~~~~~~~~~~~~~~

	latencyCheck: assert property (@(posedge clk) disable iff (reset)
		outValid === $past(inValid, 4))
	else
	begin
		$error("outValid is not inValid delayed by 4 cycles");
		failCount++;
	end

	// covers the reset cycles and the first one after
	resetCheck: assert property (@(posedge clk) reset |=> (outValid === 1'b0))
	else
	begin
		$error("outValid high during or right after reset");
		failCount++;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// argmax consistency
	// ~~~~~~~~~~~~~~~~~~~~

	winnerCheck: assert property (@(posedge clk) disable iff (reset)
		result.winValue === result.values[result.winner])
	else
	begin
		$error("winValue differs from values[winner]");
		failCount++;
	end

endmodule

bind denseLayer denseLayer_chk uCheck (
	.clk      (clk),
	.reset    (reset),
	.inValid  (inValid),
	.outValid (outValid),
	.result   (result)
);

`default_nettype wire

// ==== bench/denseLayerTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module denseLayerTb;

	import nnLayerPkg::*;

	localparam int CLK_PERIOD     = 40;
	localparam int DRIVE_DELAY    = 2;
	localparam int RESET_CYCLES   = 8;
	localparam int LATENCY        = 4;
	localparam int RANDOM_VECTORS = 32;
	localparam int NUM_VECTORS    = 5 + INPUTS + RANDOM_VECTORS; // three single vectors plus two for the tie
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_VECTORS + 50;

	typedef logic [NEURONS-1:0][DATA_W-1:0] neuronValues_t;

	// model result plus the cycle its vector went in
	typedef struct packed {
		layerResult_t result;
		logic [31:0]  issueCycle;
	} expected_t;

	logic         clk;
	logic         reset;
	logic         inValid;
	activation_t  inData;
	logic         outValid;
	layerResult_t result;

	expected_t   expQ [$];
	int unsigned cycleCount = 0;
	integer      seed = 95910;

	denseLayer #(
		.INPUTS  (INPUTS),
		.NEURONS (NEURONS)
	) u_denseLayer (
		.clk      (clk),
		.reset    (reset),
		.inValid  (inValid),
		.inData   (inData),
		.outValid (outValid),
		.result   (result)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD/2) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~
	// failure handling
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic reportMismatch(input string msg);
		abortRun($sformatf("ERROR at %0d ns: %s", $time, msg));
	endtask

	always @(posedge clk)
	begin
		if (cycleCount >= TIMEOUT_CYCLES)
			abortRun($sformatf("timeout after %0d cycles, the tests did not finish", cycleCount));
		else
			cycleCount <= cycleCount + 1;
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// compare tasks
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic compareValues(input neuronValues_t got, input neuronValues_t exp);
		for (int n = 0; n < NEURONS; n++)
		begin
			if (got[n] !== exp[n])
				reportMismatch($sformatf("neuron %0d value 0x%04h, expected 0x%04h",
					n, got[n], exp[n]));
		end
	endtask

	task automatic compareWinner(
		input logic [WIN_W-1:0]  gotIndex,
		input logic [WIN_W-1:0]  expIndex,
		input logic [DATA_W-1:0] gotValue,
		input logic [DATA_W-1:0] expValue
	);
		if (gotIndex !== expIndex || gotValue !== expValue)
			reportMismatch($sformatf("winner %0d value 0x%04h, expected %0d value 0x%04h",
				gotIndex, gotValue, expIndex, expValue));
	endtask

	task automatic compareWord(
		input logic [DATA_W-1:0] got,
		input logic [DATA_W-1:0] exp,
		input string             what
	);
		if (got !== exp)
			reportMismatch($sformatf("%s 0x%04h, expected 0x%04h", what, got, exp));
	endtask

	task automatic compareResult(input layerResult_t got, input layerResult_t exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s 0x%h, expected 0x%h", what, got, exp));
	endtask

	task automatic compareFlag(input logic got, input logic exp, input string what);
		if (got !== exp)
			reportMismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~

	// wide sum, reduced to 16 bits at the end (same result mod 2^16)
	function automatic layerResult_t modelLayer(input activation_t v);
		layerResult_t      r;
		longint            acc;
		logic [DATA_W-1:0] wrapped;
		r = '0;
		for (int n = 0; n < NEURONS; n++)
		begin
			acc = longint'(BIASES[n]);
			for (int i = 0; i < INPUTS; i++)
				acc = acc + longint'($signed(v[i])) * longint'(WEIGHTS[n][i]);
			wrapped = acc[DATA_W-1:0];
			if (wrapped[DATA_W-1])
				r.values[n] = '0; // relu
			else
				r.values[n] = wrapped;
		end
		r.winner   = '0;
		r.winValue = r.values[0];
		for (int n = 1; n < NEURONS; n++)
		begin
			if (r.values[n] > r.winValue)
			begin
				r.winner   = WIN_W'(n);
				r.winValue = r.values[n];
			end
		end
		return r;
	endfunction

	function automatic activation_t randomVector();
		activation_t v;
		for (int i = 0; i < INPUTS; i++)
			v[i] = DATA_W'($random(seed));
		return v;
	endfunction

	function automatic activation_t singleInput(input int col, input logic [DATA_W-1:0] value);
		activation_t v;
		v      = '0;
		v[col] = value;
		return v;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~
	// drive and monitor
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic driveVector(input activation_t v);
		expected_t e;
		@(posedge clk);
		#DRIVE_DELAY;
		inValid      = 1'b1;
		inData       = v;
		e.result     = modelLayer(v);
		e.issueCycle = cycleCount;
		expQ.push_back(e);
	endtask

	task automatic endBurst();
		@(posedge clk);
		#DRIVE_DELAY;
		inValid = 1'b0;
		inData  = '0;
	endtask

	task automatic drain();
		while (expQ.size() != 0)
			@(negedge clk);
	endtask

	task automatic checkOutput();
		expected_t e;
		if (u_denseLayer.uCheck.failCount != 0)
			abortRun("an assertion bound to the DUT failed");
		else if (outValid === 1'b1)
		begin
			if (expQ.size() == 0)
				abortRun("outValid rose with no vector in flight");
			else
			begin
				e = expQ.pop_front();
				if (cycleCount != e.issueCycle + LATENCY)
					reportMismatch($sformatf("result came %0d cycles after its vector",
						cycleCount - e.issueCycle));
				compareValues(result.values, e.result.values);
				compareWinner(result.winner, e.result.winner, result.winValue, e.result.winValue);
			end
		end
		else if (outValid !== 1'b0)
			reportMismatch("outValid is unknown");
		else if (expQ.size() != 0 && cycleCount >= expQ[0].issueCycle + LATENCY)
			abortRun("outValid did not rise 4 cycles after its vector");
	endtask

	always @(negedge clk)
	begin
		if (!reset)
			checkOutput();
	end

	// ~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~

	task automatic checkResetState();
		activation_t v;
		v = randomVector();
		repeat (2)
		begin
			@(negedge clk);
			compareFlag(outValid, 1'b0, "outValid after reset");
			compareResult(result, '0, "result after reset");
		end
		driveVector(v);
		endBurst();
		while (outValid !== 1'b1) // zero until the first result
		begin
			compareResult(result, '0, "result before first vector");
			@(negedge clk);
		end
		drain();
	endtask

	task automatic checkZeroInput();
		driveVector('0);
		endBurst();
		drain();
		// biases only, 3 and 5 tie at 10
		compareWinner(result.winner, 3'd3, result.winValue, 16'd10);
	endtask

	task automatic checkNegativeClamp();
		driveVector(singleInput(3, 16'd1000)); // -25 * 1000 on neuron 0
		endBurst();
		drain();
		compareWord(result.values[0], '0, "neuron 0 output");
	endtask

	task automatic checkWeightColumns();
		logic [DATA_W-1:0] value;
		for (int i = 0; i < INPUTS; i++)
		begin
			// large enough that some products wrap
			if (i % 2)
				value = 16'hFC18;
			else
				value = 16'h0F00 + DATA_W'(i);
			driveVector(singleInput(i, value));
		end
		endBurst();
		drain();
	endtask

	task automatic checkBackToBack();
		for (int k = 0; k < RANDOM_VECTORS; k++)
			driveVector(randomVector());
		endBurst();
		drain();
	endtask

	task automatic checkTieBreak();
		driveVector('0);
		driveVector(singleInput(2, 16'd1)); // neurons 1, 3, 7 all reach 9
		endBurst();
		drain();
		compareWinner(result.winner, 3'd1, result.winValue, 16'd9);
	endtask

	initial
	begin
		reset   = 1'b1;
		inValid = 1'b0;
		inData  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;

		checkResetState();
		checkZeroInput();
		checkNegativeClamp();
		checkWeightColumns();
		checkBackToBack();
		checkTieBreak();

		if (expQ.size() == 0 && u_denseLayer.uCheck.failCount == 0)
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
		else
			abortRun("the run ended with vectors still waiting for a result");
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/nnLayerPkg.sv
source/activationInput.sv
source/reluNeuron.sv
source/argmaxOutput.sv
source/denseLayer.sv
bench/denseLayer_chk.sv
bench/denseLayerTb.sv

// ==== Bender.yml ====
package:
  name: dense_layer

sources:
  # package first, then leaf modules, then the top level
  - source/nnLayerPkg.sv
  - source/activationInput.sv
  - source/reluNeuron.sv
  - source/argmaxOutput.sv
  - source/denseLayer.sv

  # testbench and bound checker
  - target: test
    files:
      - bench/denseLayer_chk.sv
      - bench/denseLayerTb.sv
